// File: build.f
+incdir+include
logic/console_stream_pkg.sv
logic/console_ctrl_pkg.sv
logic/key_debounce.sv
logic/rx_poll_timer.sv
logic/hex_word_sender.sv
logic/console_sequencer.sv
logic/fpga_console_top.sv
tb/tb_fpga_console.sv

// File: include/console_defs.svh
// ==================================================
// Default timing and message sizes for the console
// Periods assume a 50 MHz clock, giving about 25 ms
// Lengths must match the strings in the control package
// ==================================================

`ifndef CONSOLE_DEFS_SVH
`define CONSOLE_DEFS_SVH

// Key must hold a new level this long before it counts
`define CONSOLE_DEBOUNCE_CYCLES 1250000

// Spacing of receive polls
`define CONSOLE_POLL_CYCLES 1250000

// Greeting text plus CR LF
`define CONSOLE_HELLO_LEN 26

// Address prefix ahead of the hex dump
`define CONSOLE_PREFIX_LEN 12

// Nibbles in one status word
`define CONSOLE_HEX_DIGITS 8

`endif

// File: logic/console_ctrl_pkg.sv
// ==================================================
// Sequencer states and fixed console text
// Strings hold the first character in the top byte
// ==================================================

`default_nettype none

`include "console_defs.svh"

package console_ctrl_pkg;

	// ==================================================
	// Sequencer states
	// ==================================================

	typedef enum logic [2:0] {
		// Waiting for a key or a poll
		idle,
		// Key is down, wait for it to come up
		wait_release,
		// Greeting text
		send_hello,
		// Address prefix
		send_prefix,
		// Hex dump from the word sender
		send_hex,
		// One-cycle receive window
		take_rx,
		// LED update from the received byte
		apply_rx,
		// Received byte goes back out
		echo
	} console_state_t;

	// ==================================================
	// Fixed messages
	// ==================================================

	parameter logic [8*`CONSOLE_HELLO_LEN-1:0] hello_msg = "Hello from the FPGA side\r\n";

	parameter logic [8*`CONSOLE_PREFIX_LEN-1:0] prefix_msg = "0xffc020f8: ";

endpackage

`default_nettype wire

// File: logic/console_sequencer.sv
// ==================================================
// Console FSM. Key release sends greeting, prefix and
// hex dump. Polls read one rx byte, toggle an LED on
// '0'..'7' and echo it. Greeting must be the longer text
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "console_defs.svh"

module console_sequencer
	import console_stream_pkg::*;
	import console_ctrl_pkg::*;
(
	input  logic        pll_0_clock,
	input  logic        master_reset_n,
	input  logic        pressed,
	input  logic        poll_tick,
	output logic        hex_start,
	input  byte_beat_t  hex_tx,
	output logic        hex_ready,
	input  logic        hex_done,
	output byte_beat_t  tx,
	input  logic        tx_ready,
	input  byte_beat_t  rx,
	output logic        rx_ready,
	output led_vector_t leds
);

	// Counter sized for the longest message
	localparam int MSG_CNT_W = $clog2(`CONSOLE_HELLO_LEN);

	console_state_t       state;
	// Counts down, character index into the message
	logic [MSG_CNT_W-1:0] msg_cnt;
	console_byte_t        rx_byte;
	led_vector_t          led_reg;
	logic                 tx_xfer;
	logic                 msg_last;
	logic                 rx_is_led_digit;

	assign tx_xfer  = tx.valid && tx_ready;
	assign msg_last = (msg_cnt == '0);

	// ASCII '0' through '7'
	assign rx_is_led_digit = (rx_byte >= 8'h30) && (rx_byte <= 8'h37);

	// Sender starts as the last prefix character leaves
	assign hex_start = (state == send_prefix) && tx_xfer && msg_last;
	// Sender sees tx back-pressure only while it owns tx
	assign hex_ready = (state == send_hex) && tx_ready;
	// Open for exactly the one take_rx cycle
	assign rx_ready  = (state == take_rx);
	assign leds      = led_reg;

	// ==================================================
	// Tx source select
	// ==================================================

	always_comb begin
		case (state)
			send_hello: begin
				tx.valid = 1'b1;
				tx.data  = hello_msg[8*msg_cnt +: 8];
			end
			send_prefix: begin
				tx.valid = 1'b1;
				tx.data  = prefix_msg[8*msg_cnt +: 8];
			end
			send_hex: begin
				tx = hex_tx;
			end
			echo: begin
				tx.valid = 1'b1;
				tx.data  = rx_byte;
			end
			default: begin
				tx = '0;
			end
		endcase
	end

	// Received byte, loaded on an rx transfer
	always_ff @(posedge pll_0_clock) begin
		if (rx_ready && rx.valid) begin
			rx_byte <= rx.data;
		end
	end

	// ==================================================
	// State machine
	// ==================================================

	always_ff @(posedge pll_0_clock or negedge master_reset_n) begin
		if (!master_reset_n) begin
			state   <= idle;
			msg_cnt <= '0;
			led_reg <= '0;
		end else begin
			case (state)
				idle: begin
					// Press beats a poll in the same cycle
					if (pressed) begin
						state <= wait_release;
					end else if (poll_tick) begin
						state <= take_rx;
					end
				end
				wait_release: begin
					if (!pressed) begin
						msg_cnt <= MSG_CNT_W'(`CONSOLE_HELLO_LEN - 1);
						state   <= send_hello;
					end
				end
				send_hello: begin
					if (tx_xfer) begin
						if (msg_last) begin
							msg_cnt <= MSG_CNT_W'(`CONSOLE_PREFIX_LEN - 1);
							state   <= send_prefix;
						end else begin
							msg_cnt <= msg_cnt - 1'b1;
						end
					end
				end
				send_prefix: begin
					if (tx_xfer) begin
						if (msg_last) begin
							state <= send_hex;
						end else begin
							msg_cnt <= msg_cnt - 1'b1;
						end
					end
				end
				send_hex: begin
					if (hex_done) begin
						state <= idle;
					end
				end
				take_rx: begin
					// Nothing waiting, back to idle
					state <= rx.valid ? apply_rx : idle;
				end
				apply_rx: begin
					// Low three bits are the digit value
					if (rx_is_led_digit) begin
						led_reg[rx_byte[2:0]] <= ~led_reg[rx_byte[2:0]];
					end
					state <= echo;
				end
				echo: begin
					if (tx_xfer) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/console_stream_pkg.sv
// ==================================================
// Byte stream and status word types
// Valid and data travel together in one packed beat
// ==================================================

`default_nettype none

`include "console_defs.svh"

package console_stream_pkg;

	// ==================================================
	// Character stream
	// ==================================================

	// One ASCII character
	typedef logic [7:0] console_byte_t;

	// Stream beat, valid in the top bit
	typedef struct packed {
		logic          valid;
		console_byte_t data;
	} byte_beat_t;

	// ==================================================
	// Status word and LEDs
	// ==================================================

	// Whole word for capture, nibbles for the hex dump
	// Nibble 7 is the most significant
	typedef union packed {
		logic [31:0]                           word;
		logic [`CONSOLE_HEX_DIGITS-1:0][3:0]   nibble;
	} status_word_u;

	// One bit per board LED
	typedef logic [7:0] led_vector_t;

endpackage

`default_nettype wire

// File: logic/fpga_console_top.sv
// ==================================================
// Serial console top level
// Tx and rx are valid/ready byte streams
// Periods default to about 25 ms at 50 MHz
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "console_defs.svh"

module fpga_console_top
	import console_stream_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = `CONSOLE_DEBOUNCE_CYCLES,
	parameter int POLL_CYCLES     = `CONSOLE_POLL_CYCLES
) (
	input  logic         pll_0_clock,
	input  logic         master_reset_n,
	input  logic         key_n,
	input  status_word_u status_word,
	output byte_beat_t   tx,
	input  logic         tx_ready,
	input  byte_beat_t   rx,
	output logic         rx_ready,
	output led_vector_t  leds
);

	logic       pressed;
	logic       poll_tick;
	logic       hex_start;
	byte_beat_t hex_tx;
	logic       hex_ready;
	logic       hex_done;

	// Push button
	key_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) key_debounce_0 (
		.pll_0_clock   (pll_0_clock),
		.master_reset_n(master_reset_n),
		.key_n         (key_n),
		.pressed       (pressed)
	);

	// Slow receive poll
	rx_poll_timer #(
		.POLL_CYCLES(POLL_CYCLES)
	) rx_poll_timer_0 (
		.pll_0_clock   (pll_0_clock),
		.master_reset_n(master_reset_n),
		.poll_tick     (poll_tick)
	);

	// Hex dump of the status word
	hex_word_sender hex_word_sender_0 (
		.pll_0_clock   (pll_0_clock),
		.master_reset_n(master_reset_n),
		.start         (hex_start),
		.word          (status_word),
		.hex_tx        (hex_tx),
		.hex_ready     (hex_ready),
		.done          (hex_done)
	);

	// Main FSM
	console_sequencer console_sequencer_0 (
		.pll_0_clock   (pll_0_clock),
		.master_reset_n(master_reset_n),
		.pressed       (pressed),
		.poll_tick     (poll_tick),
		.hex_start     (hex_start),
		.hex_tx        (hex_tx),
		.hex_ready     (hex_ready),
		.hex_done      (hex_done),
		.tx            (tx),
		.tx_ready      (tx_ready),
		.rx            (rx),
		.rx_ready      (rx_ready),
		.leds          (leds)
	);

endmodule

`default_nettype wire

// File: logic/hex_word_sender.sv
// ==================================================
// Sends a 32-bit word as eight upper-case hex digits
// followed by CR LF. A start while busy is ignored.
// done pulses the cycle after the LF is accepted
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "console_defs.svh"

module hex_word_sender
	import console_stream_pkg::*;
(
	input  logic         pll_0_clock,
	input  logic         master_reset_n,
	input  logic         start,
	input  status_word_u word,
	output byte_beat_t   hex_tx,
	input  logic         hex_ready,
	output logic         done
);

	// Digits, then CR, then LF
	localparam int LAST_POS = `CONSOLE_HEX_DIGITS + 1;
	localparam int POS_W    = $clog2(LAST_POS + 1);
	localparam int NIB_W    = $clog2(`CONSOLE_HEX_DIGITS);

	status_word_u     captured;
	logic             busy;
	logic [POS_W-1:0] pos;
	logic [NIB_W-1:0] nib_idx;
	logic [3:0]       cur_nibble;
	console_byte_t    digit_char;
	logic             xfer;

	assign xfer = hex_tx.valid && hex_ready;

	// Word is only sampled on an accepted start
	always_ff @(posedge pll_0_clock) begin
		if (start && !busy) begin
			captured.word <= word.word;
		end
	end

	// ==================================================
	// Position and handshake
	// ==================================================

	always_ff @(posedge pll_0_clock or negedge master_reset_n) begin
		if (!master_reset_n) begin
			busy <= 1'b0;
			pos  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					pos  <= '0;
				end
			end else if (xfer) begin
				if (pos == POS_W'(LAST_POS)) begin
					// LF accepted
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					pos <= pos + 1'b1;
				end
			end
		end
	end

	// Most significant nibble goes first
	assign nib_idx    = NIB_W'(`CONSOLE_HEX_DIGITS - 1) - pos[NIB_W-1:0];
	assign cur_nibble = captured.nibble[nib_idx];

	// 0-9 from '0', A-F from 'A'
	assign digit_char = (cur_nibble < 4'd10) ? 8'h30 + {4'h0, cur_nibble}
	                                         : 8'h37 + {4'h0, cur_nibble};

	always_comb begin
		hex_tx.valid = busy;
		if (pos < POS_W'(`CONSOLE_HEX_DIGITS)) begin
			hex_tx.data = digit_char;
		end else if (pos == POS_W'(`CONSOLE_HEX_DIGITS)) begin
			// Carriage return
			hex_tx.data = 8'h0d;
		end else begin
			// Line feed
			hex_tx.data = 8'h0a;
		end
	end

endmodule

`default_nettype wire

// File: logic/key_debounce.sv
// ==================================================
// Debounce filter for an active-low push button
// DEBOUNCE_CYCLES must be at least 2
// Output lags the pin by the sync stages plus the period
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "console_defs.svh"

module key_debounce #(
	parameter int DEBOUNCE_CYCLES = `CONSOLE_DEBOUNCE_CYCLES
) (
	input  logic pll_0_clock,
	input  logic master_reset_n,
	input  logic key_n,
	output logic pressed
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES);

	// Two-flop synchronizer, idles released
	logic [1:0] key_sync_n;
	// Key level as seen after sync, high when pushed
	logic key_level;
	// Run length of a level that disagrees with pressed
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge pll_0_clock or negedge master_reset_n) begin
		if (!master_reset_n) begin
			key_sync_n <= 2'b11;
		end else begin
			key_sync_n <= {key_sync_n[0], key_n};
		end
	end

	assign key_level = ~key_sync_n[1];

	// Any return to the current level restarts the count
	always_ff @(posedge pll_0_clock or negedge master_reset_n) begin
		if (!master_reset_n) begin
			stable_cnt <= '0;
			pressed    <= 1'b0;
		end else if (key_level == pressed) begin
			stable_cnt <= '0;
		end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
			// New level held long enough
			stable_cnt <= '0;
			pressed    <= key_level;
		end else begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/rx_poll_timer.sv
// ==================================================
// Receive poll pacing
// One tick every POLL_CYCLES clocks, POLL_CYCLES >= 2
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "console_defs.svh"

module rx_poll_timer #(
	parameter int POLL_CYCLES = `CONSOLE_POLL_CYCLES
) (
	input  logic pll_0_clock,
	input  logic master_reset_n,
	output logic poll_tick
);

	localparam int CNT_W = $clog2(POLL_CYCLES);

	logic [CNT_W-1:0] div_cnt;
	logic             terminal;

	assign terminal = (div_cnt == CNT_W'(POLL_CYCLES - 1));

	// Wrap-around divider, tick registered at terminal count
	always_ff @(posedge pll_0_clock or negedge master_reset_n) begin
		if (!master_reset_n) begin
			div_cnt   <= '0;
			poll_tick <= 1'b0;
		end else begin
			div_cnt   <= terminal ? '0 : div_cnt + 1'b1;
			poll_tick <= terminal;
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_fpga_console.sv
// ==================================================
// Directed tests for the serial console top level
// Short periods: debounce 8, poll 32 cycles
// Tx back-pressure is random, with a fixed seed
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "console_defs.svh"

module tb_fpga_console
	import console_stream_pkg::*;
;

	localparam int DEBOUNCE = 8;
	localparam int POLL     = 32;
	// Cycle limits for each kind of wait
	localparam int TX_TIMEOUT = 200;
	localparam int RX_TIMEOUT = 200;

	// Expected text, first character in the top byte
	localparam logic [8*`CONSOLE_HELLO_LEN-1:0] hello_text = "Hello from the FPGA side\r\n";
	localparam logic [8*`CONSOLE_PREFIX_LEN-1:0] prefix_text = "0xffc020f8: ";

	logic         pll_0_clock;
	logic         master_reset_n;
	logic         key_n;
	status_word_u status_word;
	byte_beat_t   tx;
	logic         tx_ready;
	byte_beat_t   rx;
	logic         rx_ready;
	led_vector_t  leds;

	integer        seed = 32'hab68fa97;
	int            errors = 0;
	int            tests_run = 0;
	// Bytes accepted from tx, oldest first
	console_byte_t tx_q[$];
	// Expected LED state
	led_vector_t   led_model = '0;

	fpga_console_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE),
		.POLL_CYCLES    (POLL)
	) fpga_console_top_i (
		.pll_0_clock   (pll_0_clock),
		.master_reset_n(master_reset_n),
		.key_n         (key_n),
		.status_word   (status_word),
		.tx            (tx),
		.tx_ready      (tx_ready),
		.rx            (rx),
		.rx_ready      (rx_ready),
		.leds          (leds)
	);

	// 4 ns clock
	always #2 pll_0_clock = ~pll_0_clock;

	// ==================================================
	// Tx sink model
	// ==================================================

	// Record transfers, then pick the next ready level
	always @(posedge pll_0_clock) begin
		if (tx.valid && tx_ready) begin
			tx_q.push_back(tx.data);
		end
		tx_ready <= ($random(seed) & 3) != 0;
	end

	// ASCII for one nibble, upper case
	function automatic console_byte_t hex_char(input logic [3:0] n);
		if (n < 4'd10) begin
			return 8'h30 + n;
		end
		return 8'h41 + (n - 4'd10);
	endfunction

	task automatic check_byte(input string name, input console_byte_t exp,
		input console_byte_t act);
		if (exp !== act) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_leds(input string name, input led_vector_t exp,
		input led_vector_t act);
		if (exp !== act) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// Next accepted tx byte, polled between edges
	task automatic wait_tx_byte(input string name, output console_byte_t b);
		int  n;
		bit  got;
		got = 0;
		b   = '0;
		for (n = 0; n < TX_TIMEOUT && !got; n++) begin
			@(negedge pll_0_clock);
			if (tx_q.size() > 0) begin
				b   = tx_q.pop_front();
				got = 1;
			end
		end
		if (!got) begin
			$display("%s: no tx byte arrived before the timeout", name);
			errors++;
		end
	endtask

	// Offer one rx byte until the DUT takes it
	task automatic send_rx_byte(input string name, input console_byte_t b);
		int n;
		bit taken;
		taken = 0;
		@(posedge pll_0_clock);
		rx <= '{valid: 1'b1, data: b};
		for (n = 0; n < RX_TIMEOUT && !taken; n++) begin
			@(posedge pll_0_clock);
			taken = rx_ready && rx.valid;
		end
		rx <= '0;
		if (!taken) begin
			$display("%s: rx byte was never accepted", name);
			errors++;
		end
	endtask

	// Send, expect it echoed, track digit toggles
	task automatic echo_byte(input string name, input console_byte_t b);
		console_byte_t got;
		send_rx_byte(name, b);
		wait_tx_byte(name, got);
		check_byte($sformatf("%s echo", name), b, got);
		if (b >= "0" && b <= "7") begin
			led_model[b - "0"] = ~led_model[b - "0"];
		end
	endtask

	task automatic press_key(input int hold_cycles);
		@(posedge pll_0_clock);
		key_n <= 1'b0;
		repeat (hold_cycles) @(posedge pll_0_clock);
		key_n <= 1'b1;
	endtask

	task automatic report_test(input string name, input int err_at_start);
		tests_run++;
		$display("%s: %s", name, (errors == err_at_start) ? "passed" : "failed");
	endtask

	// ==================================================
	// Tests
	// ==================================================

	task automatic reset_values();
		int e0;
		e0 = errors;
		@(negedge pll_0_clock);
		check_leds("reset_values leds", '0, leds);
		check_bit("reset_values tx valid", 1'b0, tx.valid);
		check_bit("reset_values rx_ready", 1'b0, rx_ready);
		report_test("reset_values", e0);
	endtask

	task automatic greeting_and_dump();
		int            e0;
		int            i;
		console_byte_t got;
		e0 = errors;
		@(posedge pll_0_clock);
		status_word <= $random(seed);
		press_key(3 * DEBOUNCE);
		for (i = 0; i < `CONSOLE_HELLO_LEN; i++) begin
			wait_tx_byte("greeting_and_dump", got);
			check_byte($sformatf("greeting_and_dump hello[%0d]", i),
				hello_text[8*(`CONSOLE_HELLO_LEN-1-i) +: 8], got);
		end
		for (i = 0; i < `CONSOLE_PREFIX_LEN; i++) begin
			wait_tx_byte("greeting_and_dump", got);
			check_byte($sformatf("greeting_and_dump prefix[%0d]", i),
				prefix_text[8*(`CONSOLE_PREFIX_LEN-1-i) +: 8], got);
		end
		// Most significant digit first
		for (i = 0; i < `CONSOLE_HEX_DIGITS; i++) begin
			wait_tx_byte("greeting_and_dump", got);
			check_byte($sformatf("greeting_and_dump hex[%0d]", i),
				hex_char(status_word.word[4*(7-i) +: 4]), got);
		end
		wait_tx_byte("greeting_and_dump", got);
		check_byte("greeting_and_dump CR", 8'h0d, got);
		wait_tx_byte("greeting_and_dump", got);
		check_byte("greeting_and_dump LF", 8'h0a, got);
		report_test("greeting_and_dump", e0);
	endtask

	// Glitch under the debounce period sends nothing
	task automatic short_key_pulse();
		int e0;
		int n;
		e0 = errors;
		press_key(DEBOUNCE / 2);
		for (n = 0; n < 5 * POLL; n++) begin
			@(negedge pll_0_clock);
		end
		if (tx_q.size() != 0) begin
			$display("short_key_pulse: tx sent %0d bytes after a short pulse", tx_q.size());
			errors++;
			tx_q.delete();
		end
		report_test("short_key_pulse", e0);
	endtask

	task automatic led_digit_toggle();
		int e0;
		e0 = errors;
		echo_byte("led_digit_toggle '3'", "3");
		echo_byte("led_digit_toggle '5'", "5");
		echo_byte("led_digit_toggle '3'", "3");
		// Led 3 toggled twice, led 5 once
		check_leds("led_digit_toggle leds", 8'b0010_0000, leds);
		report_test("led_digit_toggle", e0);
	endtask

	task automatic non_digit_echo();
		int e0;
		e0 = errors;
		echo_byte("non_digit_echo '8'", "8");
		echo_byte("non_digit_echo 'a'", "a");
		check_leds("non_digit_echo leds", led_model, leds);
		report_test("non_digit_echo", e0);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		pll_0_clock    = 1'b0;
		master_reset_n = 1'b0;
		key_n          = 1'b1;
		status_word    = '0;
		tx_ready       = 1'b0;
		rx             = '0;
		repeat (4) @(posedge pll_0_clock);
		master_reset_n <= 1'b1;
		reset_values();
		greeting_and_dump();
		short_key_pulse();
		led_digit_toggle();
		non_digit_echo();
		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
